//--- hw/mac_io_pkg.sv
`default_nettype none

package mac_io_pkg;

  // Bus types
  typedef logic [23:1] cpu_word_addr_t;  // 68000 word address
  typedef logic [15:0] word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [2:0]  ipl_t;            // Active low
  typedef logic [6:0]  via_irq_t;

  // VIA interrupt flag bits
  localparam int INT_ONESEC   = 0;
  localparam int INT_VBLANK   = 1;
  localparam int INT_KEYREADY = 2;
  localparam int INT_KEYBIT   = 3;
  localparam int INT_KEYCLK   = 4;
  localparam int INT_T2       = 5;
  localparam int INT_T1       = 6;

  // VIA register index, address bits 12:9
  localparam logic [3:0] VIA_PORTB = 4'h0;
  localparam logic [3:0] VIA_DDRB  = 4'h2;
  localparam logic [3:0] VIA_DDRA  = 4'h3;
  localparam logic [3:0] VIA_T1CL  = 4'h4;
  localparam logic [3:0] VIA_T1CH  = 4'h5;
  localparam logic [3:0] VIA_T1LL  = 4'h6;
  localparam logic [3:0] VIA_T1LH  = 4'h7;
  localparam logic [3:0] VIA_T2CL  = 4'h8;
  localparam logic [3:0] VIA_T2CH  = 4'h9;
  localparam logic [3:0] VIA_SR    = 4'hA;
  localparam logic [3:0] VIA_ACR   = 4'hB;
  localparam logic [3:0] VIA_PCR   = 4'hC;
  localparam logic [3:0] VIA_IFR   = 4'hD;
  localparam logic [3:0] VIA_IER   = 4'hE;
  localparam logic [3:0] VIA_PORTA = 4'hF;

  localparam logic [2:0] ACR_SHIFT_IN  = 3'd3;  // ACR[4:2], shift in under ext clock
  localparam logic [2:0] ACR_SHIFT_OUT = 3'd7;  // ACR[4:2], shift out under ext clock

  localparam int    VIA_TICK_DIV    = 20;       // Clocks per timer tick
  localparam int    FRAMES_PER_SEC  = 60;
  localparam byte_t VIA_RESET_PORTA = 8'h7F;
  localparam byte_t VIA_RESET_PORTB = 8'hFF;
  localparam byte_t VIA_FILL_BYTE   = 8'hEF;    // Low byte of VIA and SCC reads
  localparam byte_t VIA_UNUSED_READ = 8'hBE;

  localparam byte_t      SCC_RESET_WR15    = 8'hF8;
  localparam logic [2:0] SCC_CMD_EXT_RESET = 3'd2;  // WR0[5:3]
  localparam int         SCC_REG_IDX_W     = 4;

  localparam ipl_t IPL_VIA  = 3'b110;
  localparam ipl_t IPL_SCC  = 3'b101;
  localparam ipl_t IPL_NONE = 3'b111;

  localparam logic [23:0] RAM_BASE_NORMAL = 24'h600000;

endpackage

`default_nettype wire

//--- hw/cpu_phase.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_phase #(
  parameter int c_slowdown = 0  // CPU runs 2^n times slower
) (
  input  logic i_clk_cpu,
  input  logic i_reset,
  output logic o_phi1,
  output logic o_phi2
);

  generate
    if (c_slowdown > 0) begin : g_slow
      logic [c_slowdown-1:0] phase_cnt;

      always_ff @(posedge i_clk_cpu) begin
        if (i_reset) begin
          phase_cnt <= '0;
          o_phi1    <= 1'b0;
          o_phi2    <= 1'b0;
        end else begin
          phase_cnt <= phase_cnt + 1'b1;
          o_phi1    <= phase_cnt == '0;                                   // Start of period
          o_phi2    <= phase_cnt == (c_slowdown)'(2 ** (c_slowdown - 1)); // Half way
        end
      end
    end else begin : g_full
      // Full speed, phi2 trails phi1 by one clock
      always_ff @(posedge i_clk_cpu) begin
        if (i_reset) begin
          o_phi1 <= 1'b0;
          o_phi2 <= 1'b0;
        end else begin
          o_phi1 <= ~o_phi1;
          o_phi2 <= o_phi1;
        end
      end
    end
  endgenerate

endmodule

`default_nettype wire

//--- hw/bus_glue.sv
`timescale 1ns/1ps
`default_nettype none

module bus_glue (
  input  mac_io_pkg::cpu_word_addr_t i_cpu_a,
  input  logic                       i_cpu_rw,
  input  logic                       i_cpu_uds_n,
  input  logic                       i_cpu_lds_n,
  input  logic [2:0]                 i_cpu_fc,
  input  logic                       i_overlay,
  input  mac_io_pkg::byte_t          i_via_rdata,
  input  mac_io_pkg::byte_t          i_scc_rdata,
  input  mac_io_pkg::word_t          i_ram_dout,
  input  mac_io_pkg::word_t          i_rom_dout,
  input  logic                       i_via_irq,
  input  logic                       i_scc_irq,
  output logic                       o_via_cs,
  output logic                       o_scc8_cs,
  output logic                       o_ram_cs,
  output logic                       o_rom_cs,
  output mac_io_pkg::word_t          o_cpu_din,
  output mac_io_pkg::ipl_t           o_ipl_n,
  output logic                       o_vpa_n
);
  import mac_io_pkg::*;

  logic scc_sel;

  // ===================================================================
  // Address decode on the top nibble
  // ===================================================================
  always_comb begin
    o_via_cs = 1'b0;
    scc_sel  = 1'b0;
    o_ram_cs = 1'b0;
    o_rom_cs = 1'b0;
    casez (i_cpu_a[23:20])
      4'b00??: begin                                 // Low memory, swapped by overlay
        o_ram_cs = i_overlay;
        o_rom_cs = ~i_overlay;
      end
      4'b0100: o_rom_cs = ~i_cpu_a[17];              // ROM, mirrors above 128k dropped
      RAM_BASE_NORMAL[23:20]: o_ram_cs = ~i_overlay;
      4'b10?1: scc_sel  = 1'b1;
      4'b1110: o_via_cs = 1'b1;
      default: ;                                     // SCSI at 5, IWM at D, holes
    endcase
  end

  assign o_scc8_cs = scc_sel & (~i_cpu_lds_n | ~i_cpu_uds_n);  // Needs a data strobe

  // ===================================================================
  // CPU read data
  // ===================================================================
  always_comb begin
    if (!i_cpu_rw)
      o_cpu_din = '0;                                 // CPU owns the bus on writes
    else if (o_via_cs)
      o_cpu_din = {i_via_rdata, VIA_FILL_BYTE};       // 8-bit peripherals on high byte
    else if (o_scc8_cs)
      o_cpu_din = {i_scc_rdata, VIA_FILL_BYTE};
    else if (o_ram_cs)
      o_cpu_din = i_ram_dout;
    else if (o_rom_cs)
      o_cpu_din = i_rom_dout;
    else
      o_cpu_din = '0;                                 // Unmapped, SCSI and IWM
  end

  // Interrupts, VIA wins over SCC
  assign o_ipl_n = i_via_irq ? IPL_VIA  :
                   i_scc_irq ? IPL_SCC  : IPL_NONE;
  assign o_vpa_n = ~&i_cpu_fc;                        // Auto-vector on IACK cycle

endmodule

`default_nettype wire

//--- hw/via_timer2.sv
`timescale 1ns/1ps
`default_nettype none

module via_timer2 (
  input  logic              i_clk_cpu,
  input  logic              i_reset,
  input  logic              i_load,
  input  mac_io_pkg::word_t i_load_value,
  output mac_io_pkg::word_t o_count,
  output logic              o_underflow
);
  import mac_io_pkg::*;

  logic [4:0] tick_div;
  logic       tick;
  logic       armed;           // Cleared after first underflow

  assign tick = tick_div == '0;

  // Timer tick every VIA_TICK_DIV clocks
  always_ff @(posedge i_clk_cpu) begin
    if (i_reset || tick_div == 5'(VIA_TICK_DIV - 1))
      tick_div <= '0;
    else
      tick_div <= tick_div + 1'b1;
  end

  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      o_count     <= '0;
      armed       <= 1'b0;
      o_underflow <= 1'b0;
    end else begin
      o_underflow <= 1'b0;
      if (i_load) begin
        o_count <= i_load_value;
        armed   <= 1'b1;
      end else if (tick) begin
        if (armed && o_count == '0) begin  // One shot
          o_underflow <= 1'b1;
          armed       <= 1'b0;
        end
        o_count <= o_count - 1'b1;         // Keeps running past zero
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/via_regs.sv
`timescale 1ns/1ps
`default_nettype none

module via_regs (
  input  logic              i_clk_cpu,
  input  logic              i_reset,
  input  logic              i_cs,
  input  logic              i_cpu_rw,
  input  logic              i_cpu_uds_n,
  input  logic [3:0]        i_reg,
  input  mac_io_pkg::byte_t i_wdata,
  input  logic              i_vsync,
  input  logic              i_hsync,
  input  logic              i_mouse_x2,
  input  logic              i_mouse_y2,
  input  logic              i_mouse_button,
  input  mac_io_pkg::byte_t i_kbd_in_data,
  input  logic              i_kbd_in_strobe,
  output mac_io_pkg::byte_t o_rdata,
  output logic              o_irq,
  output logic              o_overlay,
  output logic              o_disk_sel,
  output logic              o_audio,
  output mac_io_pkg::byte_t o_kbd_out_data,
  output logic              o_kbd_out_strobe
);
  import mac_io_pkg::*;

  byte_t    porta, portb, acr, sr, t2_latch_lo;
  logic     ddrb0;                     // Only bit 0 of DDRB is writable
  via_irq_t ifr, ier;
  word_t    t1_count, t1_latch, t2_count;
  logic [1:0] vsync_q;                 // Sync and edge stage
  logic [5:0] frame_cnt;
  logic     wr, rd, t2_load, t2_underflow, sr_wr, sr_wr_q, shift_in, shift_out, vblank;

  assign wr        = i_cs & ~i_cpu_rw & ~i_cpu_uds_n;
  assign rd        = i_cs & i_cpu_rw & ~i_cpu_uds_n;
  assign t2_load   = wr && i_reg == VIA_T2CH;
  assign sr_wr     = wr && i_reg == VIA_SR;
  assign shift_in  = acr[4:2] == ACR_SHIFT_IN;
  assign shift_out = acr[4:2] == ACR_SHIFT_OUT;
  assign vblank    = vsync_q[1] & ~vsync_q[0];   // Falling edge of vsync

  via_timer2 via_timer2_inst (
    .i_clk_cpu   (i_clk_cpu),
    .i_reset     (i_reset),
    .i_load      (t2_load),
    .i_load_value({i_wdata, t2_latch_lo}),
    .o_count     (t2_count),
    .o_underflow (t2_underflow)
  );

  // ===================================================================
  // Control registers and interrupt flags
  // ===================================================================
  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      porta <= VIA_RESET_PORTA;
      portb <= VIA_RESET_PORTB;
      ddrb0 <= 1'b1;
      acr   <= '0;
      ifr   <= '0;
      ier   <= '0;
      vsync_q   <= '1;
      frame_cnt <= '0;
      sr_wr_q   <= 1'b0;
      o_kbd_out_strobe <= 1'b0;
    end else begin
      vsync_q <= {vsync_q[0], i_vsync};
      sr_wr_q <= sr_wr;
      o_kbd_out_strobe <= sr_wr & ~sr_wr_q & shift_out;  // Once per bus cycle
      if (wr) begin
        case (i_reg)
          VIA_PORTB: portb <= i_wdata;
          VIA_DDRB:  ddrb0 <= i_wdata[0];
          VIA_T1CH:  ifr[INT_T1] <= 1'b0;
          VIA_T2CH:  ifr[INT_T2] <= 1'b0;                  // Reload rearms
          VIA_SR:    if (shift_out) ifr[INT_KEYREADY] <= 1'b1;
          VIA_ACR:   acr <= i_wdata;
          VIA_IFR:   ifr <= ifr & ~i_wdata[6:0];           // Write 1 to clear
          VIA_IER:   ier <= i_wdata[7] ? (ier | i_wdata[6:0]) : (ier & ~i_wdata[6:0]);
          VIA_PORTA: porta <= i_wdata;
          default: ;
        endcase
      end else if (rd) begin                               // Read side effects
        case (i_reg)
          VIA_PORTB: begin
            ifr[INT_KEYCLK] <= 1'b0;
            ifr[INT_KEYBIT] <= 1'b0;
          end
          VIA_T1CL:  ifr[INT_T1] <= 1'b0;
          VIA_T2CL:  ifr[INT_T2] <= 1'b0;
          VIA_SR:    ifr[INT_KEYREADY] <= 1'b0;
          VIA_PORTA: begin
            ifr[INT_ONESEC] <= 1'b0;
            ifr[INT_VBLANK] <= 1'b0;
          end
          default: ;
        endcase
      end
      // Events win over clears in the same clock
      if (vblank) begin
        ifr[INT_VBLANK] <= 1'b1;
        frame_cnt <= frame_cnt + 1'b1;
        if (frame_cnt == 6'(FRAMES_PER_SEC - 1)) begin
          ifr[INT_ONESEC] <= 1'b1;
          frame_cnt <= '0;
        end
      end
      if (t2_underflow) ifr[INT_T2] <= 1'b1;
      if (shift_in && i_kbd_in_strobe) ifr[INT_KEYREADY] <= 1'b1;
    end
  end

  // Timer 1 storage and shift register
  always_ff @(posedge i_clk_cpu) begin
    if (wr) begin
      case (i_reg)
        VIA_T1CL: t1_count[7:0]  <= i_wdata;
        VIA_T1CH: t1_count[15:8] <= i_wdata;
        VIA_T1LL: t1_latch[7:0]  <= i_wdata;
        VIA_T1LH: t1_latch[15:8] <= i_wdata;
        VIA_T2CL: t2_latch_lo    <= i_wdata;   // Low byte waits for T2CH
        VIA_SR:   sr             <= i_wdata;
        default: ;
      endcase
    end
    if (shift_in && i_kbd_in_strobe) sr <= i_kbd_in_data;  // Keyboard byte in
  end

  // ===================================================================
  // Read mux
  // ===================================================================
  always_comb begin
    case (i_reg)
      VIA_PORTB: o_rdata = {portb[7], ~i_hsync, i_mouse_y2, i_mouse_x2, i_mouse_button,
                            portb[2:1], ddrb0 & portb[0]};  // No RTC behind bit 0
      VIA_DDRB:  o_rdata = {7'b1000011, ddrb0};
      VIA_DDRA:  o_rdata = 8'h7F;
      VIA_T1CL:  o_rdata = t1_count[7:0];
      VIA_T1CH:  o_rdata = t1_count[15:8];
      VIA_T1LL:  o_rdata = t1_latch[7:0];
      VIA_T1LH:  o_rdata = t1_latch[15:8];
      VIA_T2CL:  o_rdata = t2_count[7:0];
      VIA_T2CH:  o_rdata = t2_count[15:8];
      VIA_SR:    o_rdata = sr;
      VIA_ACR:   o_rdata = acr;
      VIA_PCR:   o_rdata = '0;
      VIA_IFR:   o_rdata = {o_irq, ifr};              // Bit 7 is any enabled flag
      VIA_IER:   o_rdata = {1'b0, ier};
      VIA_PORTA: o_rdata = {1'b1, porta[6:0]};        // SCC write request always high
      default:   o_rdata = VIA_UNUSED_READ;
    endcase
  end

  assign o_irq          = |(ifr & ier);
  assign o_overlay      = ~porta[4];
  assign o_disk_sel     = porta[5];
  assign o_audio        = portb[7];
  assign o_kbd_out_data = sr;

endmodule

`default_nettype wire

//--- hw/scc_mouse.sv
`timescale 1ns/1ps
`default_nettype none

module scc_mouse (
  input  logic              i_clk_cpu,
  input  logic              i_reset,
  input  logic              i_cep,
  input  logic              i_cen,
  input  logic              i_cs8,
  input  logic              i_cpu_rw,
  input  logic              i_cpu_as_n,
  input  logic [1:0]        i_rs,       // Bit 0 high for channel A, bit 1 high for data
  input  mac_io_pkg::byte_t i_wdata,
  input  logic              i_mouse_x1,
  input  logic              i_mouse_y1,
  output mac_io_pkg::byte_t o_rdata,
  output logic              o_irq
);
  import mac_io_pkg::*;

  // Channel arrays indexed like i_rs[0], 1 is A and 0 is B
  logic [SCC_REG_IDX_W-1:0] rindex, rindex_latch;
  logic [1:0][7:0] wr1, wr15;       // WR1 bit 0 ext int enable, WR15 bit 3 DCD enable
  logic [5:0]      wr9;             // Bit 3 master interrupt enable
  logic [1:0]      dcd_in, dcd_latch, latch_open, ex_ip, dcd_ip, do_latch, ext_reset;
  logic [1:0]      wreg, ch_reset;
  logic            wr9_hit, full_reset;
  logic [2:0]      vec_stat;

  assign dcd_in     = {i_mouse_x1, i_mouse_y1};
  assign wreg       = {2{i_cs8 & ~i_cpu_rw & ~i_rs[1]}} & {i_rs[0], ~i_rs[0]};
  assign wr9_hit    = |wreg && rindex == 4'd9;
  assign full_reset = (wr9_hit && i_wdata[7:6] == 2'b11) || i_reset;
  assign ch_reset   = {wr9_hit && i_wdata[7:6] == 2'b10,
                       wr9_hit && i_wdata[7:6] == 2'b01} | {2{full_reset}};

  always_comb begin
    for (int ch = 0; ch < 2; ch++) begin
      ext_reset[ch] = wreg[ch] && rindex == '0 && i_wdata[5:3] == SCC_CMD_EXT_RESET;
      dcd_ip[ch]    = (dcd_in[ch] != dcd_latch[ch]) & wr15[ch][3];
      do_latch[ch]  = latch_open[ch] & dcd_ip[ch];
    end
  end

  // WR1 and WR9, channel reset keeps WR1 bits 2 and 5
  always_ff @(posedge i_clk_cpu) begin
    if (i_reset) begin
      wr9 <= '0;
      wr1 <= '0;
    end else if (i_cen) begin
      if (wr9_hit) wr9 <= i_wdata[5:0];
      for (int ch = 0; ch < 2; ch++) begin
        if (ch_reset[ch])
          wr1[ch] <= {2'b00, wr1[ch][5], 2'b00, wr1[ch][2], 2'b00};
        else if (wreg[ch] && rindex == 4'd1)
          wr1[ch] <= i_wdata;
      end
    end
  end

  // Pointer takes effect once the strobe is gone
  always_ff @(posedge i_clk_cpu) begin
    if (i_reset)
      rindex <= '0;
    else if (i_cen && i_cpu_as_n)
      rindex <= rindex_latch;
  end

  // ===================================================================
  // Pointer, WR15 and DCD latches
  // ===================================================================
  always_ff @(posedge i_clk_cpu) begin
    if (full_reset) begin
      rindex_latch <= '0;
      ex_ip        <= '0;
      latch_open   <= '1;
      dcd_latch    <= '0;
      wr15         <= {2{SCC_RESET_WR15}};
    end else begin
      if (i_cen) begin
        if (i_cs8 && !i_rs[1]) begin             // Any control access falls back to 0
          rindex_latch <= '0;
          if (!i_cpu_rw && rindex == '0)
            rindex_latch <= {i_wdata[5:3] == 3'b001, i_wdata[2:0]};  // Point high cmd
        end
        for (int ch = 0; ch < 2; ch++)
          if (wreg[ch] && rindex == 4'd15) wr15[ch] <= i_wdata;
      end
      if (i_cep) begin
        for (int ch = 0; ch < 2; ch++) begin
          if (ext_reset[ch]) begin               // Reopen latch, drop pending
            latch_open[ch] <= 1'b1;
            ex_ip[ch]      <= 1'b0;
          end else if (do_latch[ch]) begin
            latch_open[ch] <= 1'b0;
            if (wr1[ch][0]) ex_ip[ch] <= 1'b1;
          end
          if (do_latch[ch]) dcd_latch[ch] <= dcd_in[ch];
        end
      end
    end
  end

  // RR2B status, A first then B
  assign vec_stat = ex_ip[1] ? 3'b101 : ex_ip[0] ? 3'b001 : 3'b011;

  always_comb begin
    if (rindex == 4'd0)
      o_rdata = {4'b0100, wr15[i_rs[0]][3] ? dcd_latch[i_rs[0]] : dcd_in[i_rs[0]], 3'b100};
    else if (rindex == 4'd2 && !i_rs[0])
      o_rdata = {4'b0000, vec_stat, 1'b0};
    else if (rindex == 4'd3 && i_rs[0])
      o_rdata = {4'b0000, ex_ip[1], 2'b00, ex_ip[0]};  // RR3A
    else
      o_rdata = '0;
  end

  assign o_irq = wr9[3] & |ex_ip;

endmodule

`default_nettype wire

//--- hw/mac_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_io_top #(
  parameter int c_slowdown = 0
) (
  input  logic                       i_clk_cpu,
  input  logic                       i_reset,
  // CPU bus
  input  mac_io_pkg::cpu_word_addr_t i_cpu_a,
  input  mac_io_pkg::word_t          i_cpu_dout,
  input  logic                       i_cpu_rw,
  input  logic                       i_cpu_as_n,
  input  logic                       i_cpu_uds_n,
  input  logic                       i_cpu_lds_n,
  input  logic [2:0]                 i_cpu_fc,
  output mac_io_pkg::word_t          o_cpu_din,
  output mac_io_pkg::ipl_t           o_ipl_n,
  output logic                       o_vpa_n,
  output logic                       o_phi1,
  output logic                       o_phi2,
  // External memories
  output logic                       o_ram_cs,
  output logic                       o_rom_cs,
  input  mac_io_pkg::word_t          i_ram_dout,
  input  mac_io_pkg::word_t          i_rom_dout,
  // Keyboard, mouse, video timing
  input  mac_io_pkg::byte_t          i_kbd_in_data,
  input  logic                       i_kbd_in_strobe,
  output mac_io_pkg::byte_t          o_kbd_out_data,
  output logic                       o_kbd_out_strobe,
  input  logic                       i_vsync,
  input  logic                       i_hsync,
  input  logic                       i_mouse_x1,
  input  logic                       i_mouse_y1,
  input  logic                       i_mouse_x2,
  input  logic                       i_mouse_y2,
  input  logic                       i_mouse_button,
  output logic                       o_audio,
  output logic                       o_disk_sel
);

  logic              via_cs, scc8_cs, overlay, via_irq, scc_irq;
  mac_io_pkg::byte_t via_rdata, scc_rdata;

  cpu_phase #(.c_slowdown(c_slowdown)) cpu_phase_inst (
    .i_clk_cpu(i_clk_cpu), .i_reset(i_reset), .o_phi1(o_phi1), .o_phi2(o_phi2)
  );

  bus_glue bus_glue_inst (
    .i_cpu_a    (i_cpu_a),     .i_cpu_rw   (i_cpu_rw),    .i_cpu_uds_n(i_cpu_uds_n),
    .i_cpu_lds_n(i_cpu_lds_n), .i_cpu_fc   (i_cpu_fc),    .i_overlay  (overlay),
    .i_via_rdata(via_rdata),   .i_scc_rdata(scc_rdata),   .i_ram_dout (i_ram_dout),
    .i_rom_dout (i_rom_dout),  .i_via_irq  (via_irq),     .i_scc_irq  (scc_irq),
    .o_via_cs   (via_cs),      .o_scc8_cs  (scc8_cs),     .o_ram_cs   (o_ram_cs),
    .o_rom_cs   (o_rom_cs),    .o_cpu_din  (o_cpu_din),   .o_ipl_n    (o_ipl_n),
    .o_vpa_n    (o_vpa_n)
  );

  via_regs via_regs_inst (
    .i_clk_cpu  (i_clk_cpu),   .i_reset        (i_reset),        .i_cs(via_cs),
    .i_cpu_rw   (i_cpu_rw),    .i_cpu_uds_n    (i_cpu_uds_n),    .i_reg(i_cpu_a[12:9]),
    .i_wdata    (i_cpu_dout[15:8]), .i_vsync   (i_vsync),        .i_hsync(i_hsync),
    .i_mouse_x2 (i_mouse_x2),  .i_mouse_y2     (i_mouse_y2),     .i_mouse_button(i_mouse_button),
    .i_kbd_in_data(i_kbd_in_data), .i_kbd_in_strobe(i_kbd_in_strobe),
    .o_rdata    (via_rdata),   .o_irq          (via_irq),        .o_overlay(overlay),
    .o_disk_sel (o_disk_sel),  .o_audio        (o_audio),
    .o_kbd_out_data(o_kbd_out_data), .o_kbd_out_strobe(o_kbd_out_strobe)
  );

  scc_mouse scc_mouse_inst (
    .i_clk_cpu (i_clk_cpu),    .i_reset   (i_reset),         .i_cep  (o_phi1),
    .i_cen     (o_phi2),       .i_cs8     (scc8_cs),         .i_cpu_rw(i_cpu_rw),
    .i_cpu_as_n(i_cpu_as_n),   .i_rs      (i_cpu_a[2:1]),    .i_wdata(i_cpu_dout[15:8]),
    .i_mouse_x1(i_mouse_x1),   .i_mouse_y1(i_mouse_y1),
    .o_rdata   (scc_rdata),    .o_irq     (scc_irq)
  );

endmodule

`default_nettype wire

//--- tests/tb_mac_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mac_io;
  import mac_io_pkg::*;

  localparam int CLK_HALF       = 4;      // 8 ns period
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = 20000;  // About ten times the ~2000 clocks the tests take
  localparam logic [23:0] SCC_CTRL_A = 24'h900002;  // Control port of channel A

  logic           clk_cpu;
  logic           reset;
  cpu_word_addr_t cpu_a;
  word_t          cpu_dout, cpu_din, ram_dout, rom_dout;
  logic           cpu_rw, cpu_as_n, cpu_uds_n, cpu_lds_n;
  logic [2:0]     cpu_fc;
  ipl_t           ipl_n;
  logic           vpa_n, phi1, phi2, ram_cs, rom_cs;
  byte_t          kbd_in_data, kbd_out_data;
  logic           kbd_in_strobe, kbd_out_strobe;
  logic           vsync, hsync, mouse_x1, mouse_y1, mouse_x2, mouse_y2, mouse_button;
  logic           audio, disk_sel;

  integer seed = 47764;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_passed = 0;
  int     cycle_count = 0;
  int     kbd_strobes = 0;
  byte_t  kbd_seen;
  logic   snap_ram_cs, snap_rom_cs, snap_vpa_n;  // Captured mid bus cycle

  mac_io_top mac_io_top_inst (
    .i_clk_cpu(clk_cpu),           .i_reset(reset),
    .i_cpu_a(cpu_a),               .i_cpu_dout(cpu_dout),
    .i_cpu_rw(cpu_rw),             .i_cpu_as_n(cpu_as_n),
    .i_cpu_uds_n(cpu_uds_n),       .i_cpu_lds_n(cpu_lds_n),
    .i_cpu_fc(cpu_fc),             .o_cpu_din(cpu_din),
    .o_ipl_n(ipl_n),               .o_vpa_n(vpa_n),
    .o_phi1(phi1),                 .o_phi2(phi2),
    .o_ram_cs(ram_cs),             .o_rom_cs(rom_cs),
    .i_ram_dout(ram_dout),         .i_rom_dout(rom_dout),
    .i_kbd_in_data(kbd_in_data),   .i_kbd_in_strobe(kbd_in_strobe),
    .o_kbd_out_data(kbd_out_data), .o_kbd_out_strobe(kbd_out_strobe),
    .i_vsync(vsync),               .i_hsync(hsync),
    .i_mouse_x1(mouse_x1),         .i_mouse_y1(mouse_y1),
    .i_mouse_x2(mouse_x2),         .i_mouse_y2(mouse_y2),
    .i_mouse_button(mouse_button), .o_audio(audio),
    .o_disk_sel(disk_sel)
  );

  initial begin
    clk_cpu = 1'b0;
    forever #CLK_HALF clk_cpu = ~clk_cpu;
  end

  always @(posedge clk_cpu) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Keyboard strobe monitor, sampled mid clock
  always @(negedge clk_cpu) begin
    if (kbd_out_strobe) begin
      kbd_strobes++;
      kbd_seen = kbd_out_data;
    end
  end

  // ====================================================================
  // Checks and bus helpers
  // ====================================================================
  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  function automatic byte_t rand_byte();
    integer r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic [23:0] via_addr(input logic [3:0] idx);
    return 24'hE00000 | (24'(idx) << 9);  // Register index on A12..A9
  endfunction

  // One CPU cycle, 4 clocks of strobe then idle
  task automatic bus_cycle(input logic [23:0] addr, input logic rw, input byte_t wdata,
                           output word_t rdata);
    @(posedge clk_cpu);
    #1;
    cpu_a     = addr[23:1];
    cpu_rw    = rw;
    cpu_dout  = {wdata, 8'h00};  // 8-bit peripherals sit on D15..D8
    cpu_as_n  = 1'b0;
    cpu_uds_n = 1'b0;
    cpu_lds_n = 1'b0;
    @(negedge clk_cpu);
    rdata       = cpu_din;       // Before any read side effect
    snap_ram_cs = ram_cs;
    snap_rom_cs = rom_cs;
    snap_vpa_n  = vpa_n;
    repeat (4) @(posedge clk_cpu);
    #1;
    cpu_as_n  = 1'b1;
    cpu_uds_n = 1'b1;
    cpu_lds_n = 1'b1;
    cpu_rw    = 1'b1;
    @(posedge clk_cpu);
    #1;
  endtask

  task automatic bus_write(input logic [23:0] addr, input byte_t data);
    word_t unused;
    bus_cycle(addr, 1'b0, data, unused);
  endtask

  task automatic bus_read(input logic [23:0] addr, output word_t data);
    bus_cycle(addr, 1'b1, 8'h00, data);
  endtask

  // Counts clocks until the interrupt level shows up
  task automatic wait_ipl(input ipl_t level, input int limit, output int waited);
    waited = 0;
    @(negedge clk_cpu);
    while (ipl_n !== level && waited < limit) begin
      @(negedge clk_cpu);
      waited++;
    end
  endtask

  task automatic reg_roundtrip(input logic [3:0] idx, input string name);
    byte_t val;
    word_t rd;
    val = rand_byte();
    bus_write(via_addr(idx), val);
    bus_read(via_addr(idx), rd);
    check_hex(name, rd[15:8], val);
  endtask

  task automatic pulse_vsync();
    @(posedge clk_cpu);
    #1 vsync = 1'b0;             // Falling edge is the frame mark
    repeat (4) @(posedge clk_cpu);
    #1 vsync = 1'b1;
    repeat (4) @(posedge clk_cpu);
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin
    word_t rd;
    byte_t b;
    int    n;
    int    waited;
    int    mark;
    logic  phi1_prev;

    reset = 1'b1;
    cpu_a = '0;
    cpu_dout = '0;
    cpu_rw = 1'b1;
    cpu_as_n = 1'b1;
    cpu_uds_n = 1'b1;
    cpu_lds_n = 1'b1;
    cpu_fc = 3'b101;             // Supervisor data
    ram_dout = 16'h1234;
    rom_dout = 16'h4321;
    kbd_in_data = '0;
    kbd_in_strobe = 1'b0;
    vsync = 1'b1;
    hsync = 1'b1;
    mouse_x1 = 1'b0;
    mouse_y1 = 1'b0;
    mouse_x2 = 1'b0;
    mouse_y2 = 1'b1;
    mouse_button = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_cpu);
    #1 reset = 1'b0;

    // Decode and overlay
    mark = errors;
    ram_dout = {rand_byte(), rand_byte()};
    rom_dout = {rand_byte(), rand_byte()};
    // Full speed phase, phi1 flips each clock and phi2 trails it
    @(negedge clk_cpu);
    phi1_prev = phi1;
    for (int k = 0; k < 4; k++) begin
      @(negedge clk_cpu);
      check_hex("o_phi1", phi1, !phi1_prev);
      check_hex("o_phi2", phi2, phi1_prev);
      phi1_prev = phi1;
    end
    bus_read(24'h600000, rd);
    check_hex("o_ram_cs", snap_ram_cs, 1'b1);
    check_hex("o_cpu_din", rd, ram_dout);
    bus_read(24'h400000, rd);
    check_hex("o_rom_cs", snap_rom_cs, 1'b1);
    check_hex("o_cpu_din", rd, rom_dout);
    bus_read(24'h000000, rd);
    check_hex("o_rom_cs", snap_rom_cs, 1'b1);       // ROM low after reset
    bus_write(via_addr(VIA_PORTA), 8'h6F);           // Bit 4 clear, disk select set
    check_hex("o_disk_sel", disk_sel, 1'b1);
    bus_read(24'h000000, rd);
    check_hex("o_ram_cs", snap_ram_cs, 1'b1);
    check_hex("o_cpu_din", rd, ram_dout);
    bus_read(24'h700000, rd);
    check_hex("o_cpu_din", rd, 16'h0000);           // Unmapped
    bus_read(via_addr(VIA_PORTA), rd);
    check_hex("o_cpu_din", rd, {1'b1, 7'h6F, 8'hEF});
    check_hex("o_vpa_n", snap_vpa_n, 1'b1);
    cpu_fc = 3'b111;                                 // IACK cycle
    bus_read(24'h700000, rd);
    check_hex("o_vpa_n", snap_vpa_n, 1'b0);
    cpu_fc = 3'b101;
    finish_test("address decode", mark);

    // Register round trip
    mark = errors;
    reg_roundtrip(VIA_ACR, "ACR");
    reg_roundtrip(VIA_T1CL, "T1CL");
    reg_roundtrip(VIA_T1CH, "T1CH");
    reg_roundtrip(VIA_T1LL, "T1LL");
    reg_roundtrip(VIA_T1LH, "T1LH");
    for (int i = 0; i < 2; i++) begin
      b = rand_byte();
      b[7] = i[0];                                   // Audio bit both ways
      bus_write(via_addr(VIA_PORTB), b);
      bus_read(via_addr(VIA_PORTB), rd);
      // Pins read H4 low, Y2 high, X2 low, button high
      check_hex("PORTB", rd[15:8], {b[7], 4'b0101, b[2:0]});
      check_hex("o_audio", audio, b[7]);
    end
    finish_test("via registers", mark);

    // Vertical blank and one second
    mark = errors;
    bus_write(via_addr(VIA_IER), 8'h82);
    @(posedge clk_cpu);
    #1 vsync = 1'b0;
    wait_ipl(IPL_VIA, 3, waited);
    check_hex("o_ipl_n", ipl_n, IPL_VIA);
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[7]", rd[15], 1'b1);
    check_hex("IFR[1]", rd[9], 1'b1);
    vsync = 1'b1;
    bus_read(via_addr(VIA_PORTA), rd);               // Clears the flag
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[1]", rd[9], 1'b0);
    check_hex("o_ipl_n", ipl_n, IPL_NONE);
    for (int f = 1; f < FRAMES_PER_SEC - 1; f++)
      pulse_vsync();
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[0]", rd[8], 1'b0);              // 59 frames so far
    pulse_vsync();
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[0]", rd[8], 1'b1);
    bus_read(via_addr(VIA_PORTA), rd);
    bus_write(via_addr(VIA_IER), 8'h02);             // Bit 7 low clears
    finish_test("vertical blank", mark);

    // Timer 2 one shot
    mark = errors;
    bus_write(via_addr(VIA_IER), 8'hA0);
    n = 1 + (rand_byte() & 7);
    bus_write(via_addr(VIA_T2CL), byte_t'(n));
    bus_write(via_addr(VIA_T2CH), 8'h00);            // Load and arm
    wait_ipl(IPL_VIA, (n + 2) * VIA_TICK_DIV + 5, waited);
    check_hex("o_ipl_n", ipl_n, IPL_VIA);
    check_cond(waited >= n * VIA_TICK_DIV && waited <= (n + 2) * VIA_TICK_DIV,
               $sformatf("Timer 2 with count %0d fired after %0d clocks", n, waited));
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[5]", rd[13], 1'b1);
    bus_read(via_addr(VIA_T2CL), rd);
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[5]", rd[13], 1'b0);
    check_hex("o_ipl_n", ipl_n, IPL_NONE);
    bus_write(via_addr(VIA_IER), 8'h20);
    finish_test("timer 2", mark);

    // Keyboard shift register
    mark = errors;
    bus_write(via_addr(VIA_ACR), 8'h0C);             // Shift in
    b = rand_byte();
    @(posedge clk_cpu);
    #1;
    kbd_in_data = b;
    kbd_in_strobe = 1'b1;
    @(posedge clk_cpu);
    #1 kbd_in_strobe = 1'b0;
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[2]", rd[10], 1'b1);
    bus_read(via_addr(VIA_SR), rd);
    check_hex("SR", rd[15:8], b);
    bus_read(via_addr(VIA_IFR), rd);
    check_hex("IFR[2]", rd[10], 1'b0);
    bus_write(via_addr(VIA_ACR), 8'h1C);             // Shift out
    kbd_strobes = 0;
    b = rand_byte();
    bus_write(via_addr(VIA_SR), b);
    repeat (4) @(posedge clk_cpu);
    check_hex("o_kbd_out_strobe count", kbd_strobes, 1);
    check_hex("o_kbd_out_data", kbd_seen, b);
    finish_test("keyboard", mark);

    // SCC mouse interrupt on channel A
    mark = errors;
    bus_write(via_addr(VIA_IER), 8'h7F);
    bus_write(via_addr(VIA_IFR), 8'h7F);
    bus_write(SCC_CTRL_A, 8'h0F);                    // Point to WR15
    bus_write(SCC_CTRL_A, 8'h08);                    // DCD interrupt enable
    bus_write(SCC_CTRL_A, 8'h01);
    bus_write(SCC_CTRL_A, 8'h01);                    // Ext interrupt enable
    bus_write(SCC_CTRL_A, 8'h09);
    bus_write(SCC_CTRL_A, 8'h08);                    // Master interrupt enable
    check_hex("o_ipl_n", ipl_n, IPL_NONE);
    @(posedge clk_cpu);
    #1 mouse_x1 = 1'b1;
    wait_ipl(IPL_SCC, 8, waited);
    check_hex("o_ipl_n", ipl_n, IPL_SCC);
    bus_write(SCC_CTRL_A, 8'h03);
    bus_read(SCC_CTRL_A, rd);
    check_hex("RR3A", rd[15:8], 8'h08);
    bus_read(SCC_CTRL_A, rd);
    check_hex("RR0A[3]", rd[11], mouse_x1);
    check_hex("o_cpu_din low byte", rd[7:0], 8'hEF);
    bus_write(SCC_CTRL_A, 8'h10);                    // Reset ext/status
    @(negedge clk_cpu);
    check_hex("o_ipl_n", ipl_n, IPL_NONE);
    finish_test("scc mouse", mark);

    $display("%0d of %0d tests passed, %0d checks, %0d errors",
             tests_passed, tests_run, checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- mac_io_top.f
hw/mac_io_pkg.sv
hw/cpu_phase.sv
hw/bus_glue.sv
hw/via_timer2.sv
hw/via_regs.sv
hw/scc_mouse.sv
hw/mac_io_top.sv
tests/tb_mac_io.sv
